//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ex_slice -f sources.f -o sim_ex_slice
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/sim_ex_slice
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

exit 0

//--- sources.f
verilog/ex_pkg.sv
verilog/id_decode.sv
verilog/id_ex_reg.sv
verilog/ex_alu.sv
verilog/ex_branch.sv
verilog/ex_divider.sv
verilog/ex_slice_top.sv
testbench/tb_ex_slice.sv

//--- testbench/ex_trace.txt
# instr pc rs1 rs2 flush | expected: result rd wb_en redirect target trap (all hex)
# result and rd count only when wb_en is 1, target only when redirect is 1.
003100B3 00001000 00000005 00000007 0 0000000C 01 1 0 00000000 0
407302B3 00001004 00000010 00000030 0 FFFFFFE0 05 1 0 00000000 0
00A4A433 00001008 FFFFFFFF 00000001 0 00000001 08 1 0 00000000 0
00A4B433 0000100C FFFFFFFF 00000001 0 00000000 08 1 0 00000000 0
40D655B3 00001010 80000000 00000004 0 F8000000 0B 1 0 00000000 0
FFF7C713 00001014 0F0F0F0F 00000000 0 F0F0F0F0 0E 1 0 00000000 0
00889813 00001018 00ABCDEF 00000000 0 ABCDEF00 10 1 0 00000000 0
4049D913 0000101C 80000010 00000000 0 F8000001 12 1 0 00000000 0
00508013 00001020 00000001 00000000 0 00000000 00 0 0 00000000 0
12345A37 00001024 00000000 00000000 0 12345000 14 1 0 00000000 0
00001A97 00001028 00000000 00000000 0 00002028 15 1 0 00000000 0
010000EF 0000102C 00000000 00000000 0 00001030 01 1 1 0000103C 0
008302E7 00001030 00002001 00000000 0 00001034 05 1 1 00002008 0
00208463 00001034 00000055 00000055 0 00000000 00 0 1 0000103C 0
00209463 00001038 00000055 00000055 0 00000000 00 0 0 00000000 0
FE41C8E3 0000103C FFFFFFF0 00000002 0 00000000 00 0 1 0000102C 0
FE41F8E3 00001040 FFFFFFF0 00000002 0 00000000 00 0 1 00001030 0
010000EF 00001044 00000000 00000000 1 00000000 00 0 0 00000000 0
003100B3 00001048 00000003 00000004 0 00000007 01 1 0 00000000 0
02C5C533 0000104C FFFFFF9C 00000007 0 FFFFFFF2 0A 1 0 00000000 0
02C5E533 00001050 FFFFFF9C 00000007 0 FFFFFFFE 0A 1 0 00000000 0
02C5D533 00001054 12345678 00000000 0 FFFFFFFF 0A 1 0 00000000 0
02C5F533 00001058 12345678 00000000 0 12345678 0A 1 0 00000000 0
02C5C533 0000105C 80000000 FFFFFFFF 0 80000000 0A 1 0 00000000 0
02C5E533 00001060 80000000 FFFFFFFF 0 00000000 0A 1 0 00000000 0
00000073 00001064 00000000 00000000 0 00000000 00 0 0 00000000 1
00002007 00001068 00000000 00000000 0 00000000 00 0 0 00000000 1

//--- testbench/tb_ex_slice.sv
`timescale 1ns/100ps
module tb_ex_slice import ex_pkg::*; ();

  logic            clk;
  logic            rst_n_i;
  logic            valid_i;
  rv_instr_u       instr_i;
  logic [XLEN-1:0] pc_i;
  logic [XLEN-1:0] rs1_data_i;
  logic [XLEN-1:0] rs2_data_i;
  logic            stall_n_i;
  logic            flush_i;
  logic            ready_o;
  logic            result_valid_o;
  logic [XLEN-1:0] result_o;
  logic [4:0]      rd_o;
  logic            wb_en_o;
  logic            redirect_o;
  logic [XLEN-1:0] target_o;
  logic            trap_o;

  // One entry per trace line in file order.
  logic [INST_LEN-1:0] instr_q[$];
  logic [XLEN-1:0]     pc_q[$];
  logic [XLEN-1:0]     rs1_q[$];
  logic [XLEN-1:0]     rs2_q[$];
  logic                flush_q[$];
  logic [XLEN-1:0]     res_q[$];
  logic [4:0]          rd_q[$];
  logic                wb_q[$];
  logic                redir_q[$];
  logic [XLEN-1:0]     tgt_q[$];
  logic                trap_q[$];

  int          cycle_cnt;
  int          cycle_limit;

  ex_slice_top u_dut (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .valid_i        (valid_i),
    .instr_i        (instr_i),
    .pc_i           (pc_i),
    .rs1_data_i     (rs1_data_i),
    .rs2_data_i     (rs2_data_i),
    .stall_n_i      (stall_n_i),
    .flush_i        (flush_i),
    .ready_o        (ready_o),
    .result_valid_o (result_valid_o),
    .result_o       (result_o),
    .rd_o           (rd_o),
    .wb_en_o        (wb_en_o),
    .redirect_o     (redirect_o),
    .target_o       (target_o),
    .trap_o         (trap_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("ERROR: timeout, the trace did not finish within %0d cycles", cycle_limit);
      abort_run();
    end
  end

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [XLEN-1:0] exp_val,
                                 input logic [XLEN-1:0] act_val);
    $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp_val, act_val);
    abort_run();
  endtask

  task automatic check_result(input logic [XLEN-1:0] exp_res, input logic [4:0] exp_rd,
                              input logic exp_wb);
    if (wb_en_o !== exp_wb)
      report_mismatch("wb_en_o", XLEN'(exp_wb), XLEN'(wb_en_o));
    if (exp_wb) begin  // Value and index only mean something on a write-back.
      if (result_o !== exp_res)
        report_mismatch("result_o", exp_res, result_o);
      if (rd_o !== exp_rd)
        report_mismatch("rd_o", XLEN'(exp_rd), XLEN'(rd_o));
    end
  endtask

  task automatic check_redirect(input logic exp_redir, input logic [XLEN-1:0] exp_tgt);
    if (redirect_o !== exp_redir)
      report_mismatch("redirect_o", XLEN'(exp_redir), XLEN'(redirect_o));
    if (exp_redir && target_o !== exp_tgt)
      report_mismatch("target_o", exp_tgt, target_o);
  endtask

  task automatic check_trap(input logic exp_trap);
    if (trap_o !== exp_trap)
      report_mismatch("trap_o", XLEN'(exp_trap), XLEN'(trap_o));
  endtask

  task automatic load_trace();
    int              fd;
    int              n;
    string           line;
    logic [XLEN-1:0] f [11];
    fd = $fopen("testbench/ex_trace.txt", "r");
    if (fd == 0) begin
      $display("ERROR: cannot open testbench/ex_trace.txt");
      abort_run();
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 0 && line[0] != "#") begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2], f[3],
                    f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
        if (n == 11) begin
          instr_q.push_back(f[0]);
          pc_q.push_back(f[1]);
          rs1_q.push_back(f[2]);
          rs2_q.push_back(f[3]);
          flush_q.push_back(f[4][0]);
          res_q.push_back(f[5]);
          rd_q.push_back(f[6][4:0]);
          wb_q.push_back(f[7][0]);
          redir_q.push_back(f[8][0]);
          tgt_q.push_back(f[9]);
          trap_q.push_back(f[10][0]);
        end else if (n > 0) begin
          $display("ERROR: trace line has %0d fields instead of 11: %s", n, line);
          abort_run();
        end
      end
    end
    $fclose(fd);
  endtask

  // Entered and left on a falling edge.
  task automatic run_line(input int idx);
    int   gap;
    int   lat;
    logic is_div;
    gap    = $urandom % 4;
    is_div = (instr_q[idx][6:0] == OPC_OP) && (instr_q[idx][31:25] == 7'b0000001) &&
             instr_q[idx][14];
    valid_i    = 1'b1;
    instr_i    = instr_q[idx];
    pc_i       = pc_q[idx];
    rs1_data_i = rs1_q[idx];
    rs2_data_i = rs2_q[idx];
    flush_i    = flush_q[idx];
    stall_n_i  = 1'b0;
    repeat (gap) begin
      @(negedge clk);
      if (result_valid_o !== 1'b0)
        report_mismatch("result_valid_o", '0, XLEN'(result_valid_o));
      check_redirect(1'b0, '0);
      check_trap(1'b0);
    end
    stall_n_i = 1'b1;
    @(negedge clk);
    lat = 1;  // Sample 1 is the cycle right after the capture edge.
    while (result_valid_o !== 1'b1 && !flush_q[idx]) begin
      if (ready_o !== 1'b0) begin
        $display("ERROR: ready_o high at %0t while a result is still pending", $time);
        abort_run();
      end
      valid_i   = 1'b0;
      flush_i   = 1'b0;
      stall_n_i = ($urandom % 2) != 0;  // A running divide must not care.
      @(negedge clk);
      lat++;
    end
    if (flush_q[idx]) begin
      if (result_valid_o !== 1'b0)
        report_mismatch("result_valid_o", '0, XLEN'(result_valid_o));
      check_redirect(1'b0, '0);
      check_trap(1'b0);
    end else begin
      if (lat != (is_div ? DIV_CYCLES + 2 : 1)) begin
        $display("ERROR: line %0d gave its result after %0d cycles", idx, lat);
        abort_run();
      end
      check_result(res_q[idx], rd_q[idx], wb_q[idx]);
      check_redirect(redir_q[idx], tgt_q[idx]);
      check_trap(trap_q[idx]);
    end
    valid_i = 1'b0;
    flush_i = 1'b0;
  endtask

  initial begin
    void'($urandom(32'h92cb));
    cycle_cnt   = 0;
    cycle_limit = 0;
    rst_n_i     = 1'b0;
    valid_i     = 1'b0;
    instr_i     = NOP_INSTR;
    pc_i        = '0;
    rs1_data_i  = '0;
    rs2_data_i  = '0;
    stall_n_i   = 1'b1;
    flush_i     = 1'b0;
    load_trace();
    if (instr_q.size() == 0) begin
      $display("ERROR: the trace holds no instructions");
      abort_run();
    end
    cycle_limit = instr_q.size() * (DIV_CYCLES + 4) + 100;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;
    if (result_valid_o !== 1'b0 || wb_en_o !== 1'b0 || ready_o !== 1'b1)
      report_mismatch("reset state {result_valid_o, wb_en_o, ready_o}", XLEN'(3'b001),
                      XLEN'({result_valid_o, wb_en_o, ready_o}));
    check_redirect(1'b0, '0);
    check_trap(1'b0);
    for (int i = 0; i < instr_q.size(); i++) begin
      run_line(i);
    end
    @(negedge clk);
    if (result_valid_o !== 1'b0)
      report_mismatch("result_valid_o", '0, XLEN'(result_valid_o));
    check_redirect(1'b0, '0);
    check_trap(1'b0);
    $display("PASS: all tests");
    $finish;
  end

endmodule

//--- verilog/ex_alu.sv
`timescale 1ns/100ps
module ex_alu import ex_pkg::*; (
  input  logic [XLEN-1:0]     pc_i,
  input  logic [XLEN-1:0]     rs1_i,
  input  logic [XLEN-1:0]     rs2_i,
  input  logic [XLEN-1:0]     imm_i,
  input  logic [ALUCTR_W-1:0] aluctr_i,
  input  logic                src1sel_i,
  input  logic [1:0]          src2sel_i,
  output logic [XLEN-1:0]     alu_res_o
);

  logic [XLEN-1:0] op1;
  logic [XLEN-1:0] op2;
  logic [4:0]      shamt;

  assign op1   = (src1sel_i == SRC1_PC) ? pc_i : rs1_i;
  assign shamt = op2[4:0];

  always_comb begin
    case (src2sel_i)
      SRC2_IMM:  op2 = imm_i;
      SRC2_FOUR: op2 = 32'd4;  // Link address for JAL and JALR.
      default:   op2 = rs2_i;
    endcase
  end

  always_comb begin
    case (aluctr_i)
      ALU_ADD:  alu_res_o = op1 + op2;
      ALU_SUB:  alu_res_o = op1 - op2;
      ALU_SLL:  alu_res_o = op1 << shamt;
      ALU_SLT:  alu_res_o = {{(XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
      ALU_SLTU: alu_res_o = {{(XLEN-1){1'b0}}, op1 < op2};
      ALU_XOR:  alu_res_o = op1 ^ op2;
      ALU_SRL:  alu_res_o = op1 >> shamt;
      ALU_SRA:  alu_res_o = $signed(op1) >>> shamt;
      ALU_OR:   alu_res_o = op1 | op2;
      ALU_AND:  alu_res_o = op1 & op2;
      ALU_LUI:  alu_res_o = op2;
      default:  alu_res_o = '0;
    endcase
  end

endmodule

//--- verilog/ex_branch.sv
`timescale 1ns/100ps
module ex_branch import ex_pkg::*; (
  input  logic [XLEN-1:0] pc_i,
  input  logic [XLEN-1:0] rs1_i,
  input  logic [XLEN-1:0] rs2_i,
  input  logic [XLEN-1:0] imm_i,
  input  logic [2:0]      funct3_i,
  input  logic            is_jal_i,
  input  logic            is_jalr_i,
  input  logic            is_brc_i,
  output logic            redirect_o,
  output logic [XLEN-1:0] target_o
);

  logic            taken;
  logic [XLEN-1:0] jalr_sum;

  always_comb begin
    case (funct3_i)
      3'b000:  taken = (rs1_i == rs2_i);
      3'b001:  taken = (rs1_i != rs2_i);
      3'b100:  taken = ($signed(rs1_i) < $signed(rs2_i));
      3'b101:  taken = ($signed(rs1_i) >= $signed(rs2_i));
      3'b110:  taken = (rs1_i < rs2_i);
      3'b111:  taken = (rs1_i >= rs2_i);
      default: taken = 1'b0;  // 010 and 011 are not branches.
    endcase
  end

  assign jalr_sum   = rs1_i + imm_i;
  assign redirect_o = is_jal_i | is_jalr_i | (is_brc_i & taken);
  assign target_o   = is_jalr_i ? {jalr_sum[XLEN-1:1], 1'b0} : pc_i + imm_i;

endmodule

//--- verilog/ex_divider.sv
`timescale 1ns/100ps
module ex_divider import ex_pkg::*; (
  input  logic                clk,
  input  logic                rst_n_i,
  input  logic                start_i,
  input  logic [DIVSEL_W-1:0] div_sel_i,
  input  logic [XLEN-1:0]     dividend_i,
  input  logic [XLEN-1:0]     divisor_i,
  output logic                busy_o,
  output logic                done_o,
  output logic [XLEN-1:0]     quot_rem_o
);

  logic [DIV_CNT_W-1:0] cnt_q;
  logic                 done_q;
  logic                 running;
  logic                 sgn;
  logic [XLEN-1:0]      dvd_abs;
  logic [XLEN-1:0]      dvs_abs;
  logic [XLEN-1:0]      quo_q;
  logic [XLEN-1:0]      rem_q;
  logic [XLEN-1:0]      dvs_q;
  logic                 rem_sel_q;
  logic                 neg_quo_q;
  logic                 neg_rem_q;
  logic [XLEN:0]        rem_shift;
  logic [XLEN:0]        diff;

  assign running = (cnt_q != '0);
  assign busy_o  = start_i | running;  // Start cycle counts as busy.
  assign done_o  = done_q;

  assign sgn     = ~div_sel_i[0];  // funct3 bit 0 marks DIVU and REMU.
  assign dvd_abs = (sgn & dividend_i[XLEN-1]) ? -dividend_i : dividend_i;
  assign dvs_abs = (sgn & divisor_i[XLEN-1]) ? -divisor_i : divisor_i;

  assign rem_shift = {rem_q, quo_q[XLEN-1]};
  assign diff      = rem_shift - {1'b0, dvs_q};

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      cnt_q  <= '0;
      done_q <= 1'b0;
    end else begin
      done_q <= (cnt_q == DIV_CNT_W'(1));
      if (start_i) begin
        cnt_q <= DIV_CNT_W'(DIV_CYCLES);
      end else if (running) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // The quotient register also shifts the dividend out, one bit per step.
  always_ff @(posedge clk) begin
    if (start_i) begin
      quo_q     <= dvd_abs;
      rem_q     <= '0;
      dvs_q     <= dvs_abs;
      rem_sel_q <= div_sel_i[1];
      neg_quo_q <= sgn & (dividend_i[XLEN-1] ^ divisor_i[XLEN-1]) & (divisor_i != '0);
      neg_rem_q <= sgn & dividend_i[XLEN-1];
    end else if (running) begin
      if (!diff[XLEN]) begin
        rem_q <= diff[XLEN-1:0];
        quo_q <= {quo_q[XLEN-2:0], 1'b1};
      end else begin
        rem_q <= rem_shift[XLEN-1:0];
        quo_q <= {quo_q[XLEN-2:0], 1'b0};
      end
    end
  end

  // Zero divisor leaves all ones and the dividend; overflow falls out of the sign fix.
  assign quot_rem_o = rem_sel_q ? (neg_rem_q ? -rem_q : rem_q)
                                : (neg_quo_q ? -quo_q : quo_q);

  a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
    start_i |-> !running);
  a_done_single: assert property (@(posedge clk) disable iff (!rst_n_i)
    done_o |=> !done_o);

endmodule

//--- verilog/ex_pkg.sv
package ex_pkg;

  localparam int XLEN       = 32;
  localparam int INST_LEN   = 32;
  localparam int ALUCTR_W   = 5;
  localparam int DIVSEL_W   = 3;
  localparam int DIV_CYCLES = 32;
  localparam int DIV_CNT_W  = $clog2(DIV_CYCLES + 1);

  localparam logic [ALUCTR_W-1:0] ALU_ADD  = 5'd0;
  localparam logic [ALUCTR_W-1:0] ALU_SUB  = 5'd1;
  localparam logic [ALUCTR_W-1:0] ALU_SLL  = 5'd2;
  localparam logic [ALUCTR_W-1:0] ALU_SLT  = 5'd3;
  localparam logic [ALUCTR_W-1:0] ALU_SLTU = 5'd4;
  localparam logic [ALUCTR_W-1:0] ALU_XOR  = 5'd5;
  localparam logic [ALUCTR_W-1:0] ALU_SRL  = 5'd6;
  localparam logic [ALUCTR_W-1:0] ALU_SRA  = 5'd7;
  localparam logic [ALUCTR_W-1:0] ALU_OR   = 5'd8;
  localparam logic [ALUCTR_W-1:0] ALU_AND  = 5'd9;
  localparam logic [ALUCTR_W-1:0] ALU_LUI  = 5'd10;  // Passes operand 2 through.

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  localparam logic       SRC1_RS1  = 1'b0;
  localparam logic       SRC1_PC   = 1'b1;
  localparam logic [1:0] SRC2_RS2  = 2'd0;
  localparam logic [1:0] SRC2_IMM  = 2'd1;
  localparam logic [1:0] SRC2_FOUR = 2'd2;

  localparam logic [INST_LEN-1:0] NOP_INSTR = 32'h0000_0013;  // addi x0, x0, 0

  // Register-register view and immediate view of the same word.
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_fmt;
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_fmt;
  } rv_instr_u;

endpackage

//--- verilog/ex_slice_top.sv
`timescale 1ns/100ps
module ex_slice_top import ex_pkg::*; (
  input  logic            clk,
  input  logic            rst_n_i,
  input  logic            valid_i,
  input  rv_instr_u       instr_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [XLEN-1:0] rs1_data_i,
  input  logic [XLEN-1:0] rs2_data_i,
  input  logic            stall_n_i,
  input  logic            flush_i,
  output logic            ready_o,
  output logic            result_valid_o,
  output logic [XLEN-1:0] result_o,
  output logic [4:0]      rd_o,
  output logic            wb_en_o,
  output logic            redirect_o,
  output logic [XLEN-1:0] target_o,
  output logic            trap_o
);

  logic [XLEN-1:0]     id_imm;
  logic [ALUCTR_W-1:0] id_aluctr;
  logic                id_src1sel;
  logic [1:0]          id_src2sel;
  logic                id_is_jal;
  logic                id_is_jalr;
  logic                id_is_brc;
  logic                id_wben;
  logic                id_div_en;
  logic [DIVSEL_W-1:0] id_div_sel;
  logic                id_trap;

  logic [XLEN-1:0]     ex_pc;
  rv_instr_u           ex_instr;
  logic [XLEN-1:0]     ex_imm;
  logic [XLEN-1:0]     ex_rs1;
  logic [XLEN-1:0]     ex_rs2;
  logic [ALUCTR_W-1:0] ex_aluctr;
  logic                ex_src1sel;
  logic [1:0]          ex_src2sel;
  logic                ex_is_jal;
  logic                ex_is_jalr;
  logic                ex_is_brc;
  logic                ex_wben;
  logic                ex_div_en;
  logic [DIVSEL_W-1:0] ex_div_sel;
  logic                ex_trap;
  logic                ex_new;

  logic [XLEN-1:0]     alu_res;
  logic                br_redirect;
  logic                div_busy;
  logic                div_done;
  logic [XLEN-1:0]     div_res;

  id_decode u_decode (
    .instr_i   (instr_i),
    .valid_i   (valid_i),
    .imm_o     (id_imm),
    .aluctr_o  (id_aluctr),
    .src1sel_o (id_src1sel),
    .src2sel_o (id_src2sel),
    .is_jal_o  (id_is_jal),
    .is_jalr_o (id_is_jalr),
    .is_brc_o  (id_is_brc),
    .wben_o    (id_wben),
    .div_en_o  (id_div_en),
    .div_sel_o (id_div_sel),
    .trap_o    (id_trap)
  );

  // A bubble enters EX the same way a flushed slot does.
  id_ex_reg u_id_ex (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .stall_n_i (stall_n_i),
    .flush_i   (flush_i | ~valid_i),
    .hold_i    (div_busy),
    .pc_i      (pc_i),
    .instr_i   (instr_i),
    .imm_i     (id_imm),
    .rs1_i     (rs1_data_i),
    .rs2_i     (rs2_data_i),
    .aluctr_i  (id_aluctr),
    .src1sel_i (id_src1sel),
    .src2sel_i (id_src2sel),
    .is_jal_i  (id_is_jal),
    .is_jalr_i (id_is_jalr),
    .is_brc_i  (id_is_brc),
    .wben_i    (id_wben),
    .div_en_i  (id_div_en),
    .div_sel_i (id_div_sel),
    .trap_i    (id_trap),
    .pc_o      (ex_pc),
    .instr_o   (ex_instr),
    .imm_o     (ex_imm),
    .rs1_o     (ex_rs1),
    .rs2_o     (ex_rs2),
    .aluctr_o  (ex_aluctr),
    .src1sel_o (ex_src1sel),
    .src2sel_o (ex_src2sel),
    .is_jal_o  (ex_is_jal),
    .is_jalr_o (ex_is_jalr),
    .is_brc_o  (ex_is_brc),
    .wben_o    (ex_wben),
    .div_en_o  (ex_div_en),
    .div_sel_o (ex_div_sel),
    .trap_o    (ex_trap),
    .ex_new_o  (ex_new)
  );

  ex_alu u_alu (
    .pc_i      (ex_pc),
    .rs1_i     (ex_rs1),
    .rs2_i     (ex_rs2),
    .imm_i     (ex_imm),
    .aluctr_i  (ex_aluctr),
    .src1sel_i (ex_src1sel),
    .src2sel_i (ex_src2sel),
    .alu_res_o (alu_res)
  );

  ex_branch u_branch (
    .pc_i       (ex_pc),
    .rs1_i      (ex_rs1),
    .rs2_i      (ex_rs2),
    .imm_i      (ex_imm),
    .funct3_i   (ex_instr.r_fmt.funct3),
    .is_jal_i   (ex_is_jal),
    .is_jalr_i  (ex_is_jalr),
    .is_brc_i   (ex_is_brc),
    .redirect_o (br_redirect),
    .target_o   (target_o)
  );

  ex_divider u_divider (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .start_i    (ex_new & ex_div_en),
    .div_sel_i  (ex_div_sel),
    .dividend_i (ex_rs1),
    .divisor_i  (ex_rs2),
    .busy_o     (div_busy),
    .done_o     (div_done),
    .quot_rem_o (div_res)
  );

  assign ready_o        = ~div_busy;
  assign result_valid_o = (ex_new & ~ex_div_en) | div_done;
  assign result_o       = ex_div_en ? div_res : alu_res;
  assign rd_o           = ex_instr.r_fmt.rd;
  assign wb_en_o        = result_valid_o & ex_wben;
  assign redirect_o     = ex_new & br_redirect;
  assign trap_o         = ex_new & ex_trap;

endmodule

//--- verilog/id_decode.sv
`timescale 1ns/100ps
module id_decode import ex_pkg::*; (
  input  rv_instr_u            instr_i,
  input  logic                 valid_i,
  output logic [XLEN-1:0]      imm_o,
  output logic [ALUCTR_W-1:0]  aluctr_o,
  output logic                 src1sel_o,
  output logic [1:0]           src2sel_o,
  output logic                 is_jal_o,
  output logic                 is_jalr_o,
  output logic                 is_brc_o,
  output logic                 wben_o,
  output logic                 div_en_o,
  output logic [DIVSEL_W-1:0]  div_sel_o,
  output logic                 trap_o
);

  logic [6:0]          opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [XLEN-1:0]     imm_i_type;
  logic [XLEN-1:0]     imm_b_type;
  logic [XLEN-1:0]     imm_j_type;
  logic [XLEN-1:0]     imm_u_type;
  logic [ALUCTR_W-1:0] alu_f3;
  logic                writes_rd;

  assign opcode    = instr_i.r_fmt.opcode;
  assign funct3    = instr_i.r_fmt.funct3;
  assign funct7    = instr_i.r_fmt.funct7;
  assign div_sel_o = funct3;

  assign imm_i_type = {{20{instr_i.i_fmt.imm12[11]}}, instr_i.i_fmt.imm12};
  assign imm_b_type = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
  assign imm_j_type = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
  assign imm_u_type = {instr_i[31:12], 12'b0};

  always_comb begin
    case (funct3)
      3'b000:  alu_f3 = (opcode == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
      3'b001:  alu_f3 = ALU_SLL;
      3'b010:  alu_f3 = ALU_SLT;
      3'b011:  alu_f3 = ALU_SLTU;
      3'b100:  alu_f3 = ALU_XOR;
      3'b101:  alu_f3 = funct7[5] ? ALU_SRA : ALU_SRL;  // imm[10] for SRAI.
      3'b110:  alu_f3 = ALU_OR;
      default: alu_f3 = ALU_AND;
    endcase
  end

  always_comb begin
    imm_o     = imm_i_type;
    aluctr_o  = alu_f3;
    src1sel_o = SRC1_RS1;
    src2sel_o = SRC2_RS2;
    is_jal_o  = 1'b0;
    is_jalr_o = 1'b0;
    is_brc_o  = 1'b0;
    div_en_o  = 1'b0;
    trap_o    = 1'b0;
    writes_rd = 1'b0;
    case (opcode)
      OPC_OP: begin
        writes_rd = 1'b1;
        if (funct7 == 7'b0000001) begin
          div_en_o = funct3[2];
          trap_o   = ~funct3[2];  // Multiply is not built.
        end
      end
      OPC_OPIMM: begin
        writes_rd = 1'b1;
        src2sel_o = SRC2_IMM;
      end
      OPC_LUI: begin
        writes_rd = 1'b1;
        aluctr_o  = ALU_LUI;
        src2sel_o = SRC2_IMM;
        imm_o     = imm_u_type;
      end
      OPC_AUIPC: begin
        writes_rd = 1'b1;
        aluctr_o  = ALU_ADD;
        src1sel_o = SRC1_PC;
        src2sel_o = SRC2_IMM;
        imm_o     = imm_u_type;
      end
      OPC_JAL: begin
        writes_rd = 1'b1;
        is_jal_o  = 1'b1;
        aluctr_o  = ALU_ADD;
        src1sel_o = SRC1_PC;
        src2sel_o = SRC2_FOUR;
        imm_o     = imm_j_type;
      end
      OPC_JALR: begin
        writes_rd = 1'b1;
        is_jalr_o = 1'b1;
        aluctr_o  = ALU_ADD;
        src1sel_o = SRC1_PC;
        src2sel_o = SRC2_FOUR;
      end
      OPC_BRANCH: begin
        is_brc_o = 1'b1;
        imm_o    = imm_b_type;
      end
      OPC_SYSTEM: trap_o = 1'b1;  // ECALL and every other SYSTEM word trap.
      default:    trap_o = 1'b1;
    endcase

    wben_o = writes_rd & ~trap_o & (instr_i.r_fmt.rd != 5'd0);

    if (!valid_i) begin
      is_jal_o  = 1'b0;
      is_jalr_o = 1'b0;
      is_brc_o  = 1'b0;
      wben_o    = 1'b0;
      div_en_o  = 1'b0;
      trap_o    = 1'b0;
    end
  end

endmodule

//--- verilog/id_ex_reg.sv
`timescale 1ns/100ps
module id_ex_reg import ex_pkg::*; (
  input  logic                clk,
  input  logic                rst_n_i,
  input  logic                stall_n_i,
  input  logic                flush_i,
  input  logic                hold_i,
  input  logic [XLEN-1:0]     pc_i,
  input  rv_instr_u           instr_i,
  input  logic [XLEN-1:0]     imm_i,
  input  logic [XLEN-1:0]     rs1_i,
  input  logic [XLEN-1:0]     rs2_i,
  input  logic [ALUCTR_W-1:0] aluctr_i,
  input  logic                src1sel_i,
  input  logic [1:0]          src2sel_i,
  input  logic                is_jal_i,
  input  logic                is_jalr_i,
  input  logic                is_brc_i,
  input  logic                wben_i,
  input  logic                div_en_i,
  input  logic [DIVSEL_W-1:0] div_sel_i,
  input  logic                trap_i,
  output logic [XLEN-1:0]     pc_o,
  output rv_instr_u           instr_o,
  output logic [XLEN-1:0]     imm_o,
  output logic [XLEN-1:0]     rs1_o,
  output logic [XLEN-1:0]     rs2_o,
  output logic [ALUCTR_W-1:0] aluctr_o,
  output logic                src1sel_o,
  output logic [1:0]          src2sel_o,
  output logic                is_jal_o,
  output logic                is_jalr_o,
  output logic                is_brc_o,
  output logic                wben_o,
  output logic                div_en_o,
  output logic [DIVSEL_W-1:0] div_sel_o,
  output logic                trap_o,
  output logic                ex_new_o
);

  logic en;

  assign en = stall_n_i & ~hold_i;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      pc_o      <= '0;
      instr_o   <= rv_instr_u'(NOP_INSTR);
      is_jal_o  <= 1'b0;
      is_jalr_o <= 1'b0;
      is_brc_o  <= 1'b0;
      wben_o    <= 1'b0;
      div_en_o  <= 1'b0;
      trap_o    <= 1'b0;
      ex_new_o  <= 1'b0;
    end else begin
      ex_new_o <= en & ~flush_i;  // A stalled slot never looks new twice.
      if (en) begin
        pc_o      <= flush_i ? '0 : pc_i;
        instr_o   <= flush_i ? rv_instr_u'(NOP_INSTR) : instr_i;
        is_jal_o  <= ~flush_i & is_jal_i;
        is_jalr_o <= ~flush_i & is_jalr_i;
        is_brc_o  <= ~flush_i & is_brc_i;
        wben_o    <= ~flush_i & wben_i;
        div_en_o  <= ~flush_i & div_en_i;
        trap_o    <= ~flush_i & trap_i;
        imm_o     <= imm_i;  // Data fields go through on flush.
        rs1_o     <= rs1_i;
        rs2_o     <= rs2_i;
        aluctr_o  <= aluctr_i;
        src1sel_o <= src1sel_i;
        src2sel_o <= src2sel_i;
        div_sel_o <= div_sel_i;
      end
    end
  end

  a_no_redirect_and_trap: assert property (@(posedge clk) disable iff (!rst_n_i)
    !((is_jal_o | is_jalr_o | is_brc_o) & trap_o));

endmodule
